//--- hdl/mmu_pkg.sv
package mmu_pkg;

    localparam int unsigned DATA_W = 32;

    // Fixed address map
    localparam logic [31:0] GPIO_DIR_BASE = 32'h0000_0101;
    localparam logic [31:0] GPIO_DIR_LAST = 32'h0000_010A;
    localparam logic [31:0] GPIO_VAL_BASE = 32'h0000_010B;
    localparam logic [31:0] GPIO_VAL_LAST = 32'h0000_0114;
    localparam logic [31:0] TIMER_ADDR    = 32'h0000_0115;
    localparam logic [31:0] SRAM_BASE     = 32'h0000_1000;
    localparam logic [31:0] SRAM_LAST     = 32'h0000_1FFF;
    localparam logic [31:0] FLASH_BASE    = 32'h0000_2000;

    localparam int unsigned GPIO_PINS  = 10;
    localparam int unsigned GPIO_IDX_W = 4;

    // Word index width of the scratch memory
    localparam int unsigned SRAM_AW = 10;

    // SPI flash read opcode
    localparam logic [7:0] FLASH_READ_CMD = 8'h03;

    typedef enum logic [3:0] {
        st_idle,
        st_sram_wait,
        st_flash_wait,
        st_respond
    } mmu_state_e;

    typedef enum logic [2:0] {
        fl_idle,
        fl_cmd,
        fl_data,
        fl_done
    } flash_state_e;

    typedef struct packed {
        logic [7:0]  cmd;
        logic [23:0] addr;
    } flash_cmd_t;

endpackage : mmu_pkg

//--- hdl/scratch_sram.sv
`timescale 1ns/1ps

module scratch_sram import mmu_pkg::*; (
    input  logic                clk,
    input  logic                en_i,
    input  logic                we_i,
    input  logic [DATA_W/8-1:0] be_i,
    input  logic [SRAM_AW-1:0]  addr_i,
    input  logic [DATA_W-1:0]   wdata_i,
    output logic [DATA_W-1:0]   rdata_o
);

    localparam int unsigned WORDS = 1 << SRAM_AW;

    logic [DATA_W-1:0] mem_q [WORDS];

    // Byte-enabled write port
    always_ff @(posedge clk) begin
        if (en_i && we_i) begin
            for (int b = 0; b < DATA_W/8; b++) begin
                if (be_i[b]) begin
                    mem_q[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
                end
            end
        end
    end

    // Registered read, valid one cycle after the strobe
    always_ff @(posedge clk) begin
        if (en_i && !we_i) begin
            rdata_o <= mem_q[addr_i];
        end
    end

endmodule : scratch_sram

//--- hdl/flash_reader.sv
`timescale 1ns/1ps

module flash_reader import mmu_pkg::*; #(
    parameter int unsigned CLK_DIV = 2
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              start_i,
    input  logic [23:0]       addr_i,
    output logic              valid_o,
    output logic [DATA_W-1:0] rdata_o,
    output logic              spi_cs_o,
    output logic              spi_sck_o,
    output logic              spi_mosi_o,
    input  logic              spi_miso_i
);

    localparam int unsigned      DIV_W    = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(CLK_DIV - 1);

    flash_state_e state_q;
    flash_cmd_t   cmd_word;

    logic             cs_q;
    logic             sck_q;
    logic [DIV_W-1:0] div_q;
    logic [4:0]       bit_q;
    logic [31:0]      tx_q;
    logic [DATA_W-1:0] rx_q;
    logic             sck_tick;

    assign cmd_word.cmd  = FLASH_READ_CMD;
    assign cmd_word.addr = addr_i;

    // SCK toggles once per CLK_DIV cycles
    assign sck_tick = (div_q == DIV_LAST);

    always_ff @(posedge clk) begin
        if (!rst) begin
            state_q <= fl_idle;
            cs_q    <= 1'b1;
            sck_q   <= 1'b0;
            div_q   <= '0;
            bit_q   <= '0;
        end else begin
            case (state_q)
                fl_idle: begin
                    if (start_i) begin
                        cs_q    <= 1'b0;
                        div_q   <= '0;
                        bit_q   <= '0;
                        state_q <= fl_cmd;
                    end
                end
                fl_cmd, fl_data: begin
                    if (sck_tick) begin
                        div_q <= '0;
                        sck_q <= ~sck_q;
                        // Bits are counted on the falling edge
                        if (sck_q) begin
                            bit_q <= bit_q + 5'd1;
                            if (bit_q == 5'd31) begin
                                state_q <= (state_q == fl_cmd) ? fl_data : fl_done;
                                if (state_q == fl_data) begin
                                    cs_q <= 1'b1;
                                end
                            end
                        end
                    end else begin
                        div_q <= div_q + 1'b1;
                    end
                end
                fl_done: state_q <= fl_idle;
                default: state_q <= fl_idle;
            endcase
        end
    end

    // Command shifts out on falling edges, data shifts in on rising edges
    always_ff @(posedge clk) begin
        if (state_q == fl_idle && start_i) begin
            tx_q <= cmd_word;
        end else if (state_q == fl_cmd && sck_tick && sck_q) begin
            tx_q <= {tx_q[30:0], 1'b0};
        end
        if (state_q == fl_data && sck_tick && !sck_q) begin
            rx_q <= {rx_q[DATA_W-2:0], spi_miso_i};
        end
    end

    assign spi_cs_o   = cs_q;
    assign spi_sck_o  = sck_q;
    assign spi_mosi_o = (state_q == fl_cmd) ? tx_q[31] : 1'b0;
    assign valid_o    = (state_q == fl_done);
    assign rdata_o    = rx_q;

endmodule : flash_reader

//--- hdl/gpio_bank.sv
`timescale 1ns/1ps

module gpio_bank import mmu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wr_i,
    input  logic                  rd_i,
    input  logic                  is_dir_i,
    input  logic [GPIO_IDX_W-1:0] index_i,
    input  logic                  wdata_i,
    output logic                  rdata_o,
    output logic                  fault_o,
    inout  wire  [GPIO_PINS-1:0]  pins_io
);

    // 1 = input, 0 = output
    logic [GPIO_PINS-1:0] dir_q;
    logic [GPIO_PINS-1:0] val_q;

    // Value writes need an output pin, value reads an input pin
    assign fault_o = !is_dir_i && ((wr_i && dir_q[index_i]) || (rd_i && !dir_q[index_i]));

    assign rdata_o = is_dir_i ? dir_q[index_i] : pins_io[index_i];

    always_ff @(posedge clk) begin
        if (!rst) begin
            dir_q <= '0;
            val_q <= '0;
        end else if (wr_i) begin
            if (is_dir_i) begin
                dir_q[index_i] <= wdata_i;
            end else if (!dir_q[index_i]) begin
                val_q[index_i] <= wdata_i;
            end
        end
    end

    // Tristate drivers, input pins float
    for (genvar i = 0; i < GPIO_PINS; i++) begin : g_pin
        assign pins_io[i] = dir_q[i] ? 1'bz : val_q[i];
    end

endmodule : gpio_bank

//--- hdl/digital_timer.sv
`timescale 1ns/1ps

module digital_timer import mmu_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              load_i,
    input  logic [DATA_W-1:0] value_i,
    output logic              is_high_o
);

    logic [DATA_W-1:0] count_q;

    always_ff @(posedge clk) begin
        if (!rst) begin
            count_q <= '0;
        end else if (load_i) begin
            count_q <= value_i;
        end else if (count_q != '0) begin
            count_q <= count_q - 1'b1;
        end
    end

    // Stays high until the count runs out
    assign is_high_o = (count_q != '0);

endmodule : digital_timer

//--- hdl/mmu.sv
`timescale 1ns/1ps

module mmu import mmu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,

    // Core side
    input  logic                  mem_req_i,
    input  logic [31:0]           mem_addr_i,
    input  logic                  mem_we_i,
    input  logic [DATA_W/8-1:0]   mem_be_i,
    input  logic [DATA_W-1:0]     mem_wdata_i,
    output logic                  mem_rvalid_o,
    output logic                  mem_err_o,
    output logic [DATA_W-1:0]     mem_rdata_o,

    // Scratch SRAM
    output logic                  sram_en_o,
    output logic                  sram_we_o,
    output logic [DATA_W/8-1:0]   sram_be_o,
    output logic [SRAM_AW-1:0]    sram_addr_o,
    output logic [DATA_W-1:0]     sram_wdata_o,
    input  logic [DATA_W-1:0]     sram_rdata_i,

    // Flash reader
    output logic                  flash_start_o,
    output logic [23:0]           flash_addr_o,
    input  logic                  flash_valid_i,
    input  logic [DATA_W-1:0]     flash_rdata_i,

    // GPIO bank
    output logic                  gpio_wr_o,
    output logic                  gpio_rd_o,
    output logic                  gpio_is_dir_o,
    output logic [GPIO_IDX_W-1:0] gpio_index_o,
    output logic                  gpio_wdata_o,
    input  logic                  gpio_rdata_i,
    input  logic                  gpio_fault_i,

    // Timer
    output logic                  timer_load_o,
    output logic [DATA_W-1:0]     timer_value_o,
    input  logic                  timer_is_high_i
);

    mmu_state_e state_q;

    logic                  req_we_q;
    logic                  resp_err_q;
    logic [DATA_W-1:0]     resp_rdata_q;

    logic hit_gpio_dir;
    logic hit_gpio_val;
    logic hit_gpio;
    logic hit_timer;
    logic hit_sram;
    logic hit_flash;
    logic hit_reserved;
    logic req_idle;

    // Address decode against the fixed map
    assign hit_gpio_dir = (mem_addr_i >= GPIO_DIR_BASE) && (mem_addr_i <= GPIO_DIR_LAST);
    assign hit_gpio_val = (mem_addr_i >= GPIO_VAL_BASE) && (mem_addr_i <= GPIO_VAL_LAST);
    assign hit_gpio     = hit_gpio_dir || hit_gpio_val;
    assign hit_timer    = (mem_addr_i == TIMER_ADDR);
    assign hit_sram     = (mem_addr_i >= SRAM_BASE) && (mem_addr_i <= SRAM_LAST);
    assign hit_flash    = (mem_addr_i >= FLASH_BASE);
    assign hit_reserved = !(hit_gpio || hit_timer || hit_sram || hit_flash);

    // New requests are only taken while idle
    assign req_idle = mem_req_i && (state_q == st_idle);

    assign sram_en_o    = req_idle && hit_sram;
    assign sram_we_o    = mem_we_i;
    assign sram_be_o    = mem_be_i;
    assign sram_addr_o  = SRAM_AW'((mem_addr_i - SRAM_BASE) >> 2);
    assign sram_wdata_o = mem_wdata_i;

    // Flash is read-only, a write never starts the reader
    assign flash_start_o = req_idle && hit_flash && !mem_we_i;
    assign flash_addr_o  = 24'(mem_addr_i - FLASH_BASE);

    assign gpio_wr_o     = req_idle && hit_gpio && mem_we_i;
    assign gpio_rd_o     = req_idle && hit_gpio && !mem_we_i;
    assign gpio_is_dir_o = hit_gpio_dir;
    assign gpio_index_o  = hit_gpio_dir ? GPIO_IDX_W'(mem_addr_i - GPIO_DIR_BASE)
                                        : GPIO_IDX_W'(mem_addr_i - GPIO_VAL_BASE);
    assign gpio_wdata_o  = mem_wdata_i[0];

    assign timer_load_o  = req_idle && hit_timer && mem_we_i;
    assign timer_value_o = mem_wdata_i;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state_q    <= st_idle;
            req_we_q   <= 1'b0;
            resp_err_q <= 1'b0;
        end else begin
            case (state_q)
                st_idle: begin
                    if (mem_req_i) begin
                        req_we_q   <= mem_we_i;
                        resp_err_q <= 1'b0;
                        if (hit_sram) begin
                            state_q <= st_sram_wait;
                        end else if (hit_flash && !mem_we_i) begin
                            state_q <= st_flash_wait;
                        end else begin
                            state_q    <= st_respond;
                            resp_err_q <= hit_reserved || hit_flash || (hit_gpio && gpio_fault_i);
                        end
                    end
                end
                st_sram_wait: state_q <= st_respond;
                st_flash_wait: begin
                    if (flash_valid_i) begin
                        state_q <= st_respond;
                    end
                end
                st_respond: state_q <= st_idle;
                default: state_q <= st_idle;
            endcase
        end
    end

    // Response data, zero for writes and errors
    always_ff @(posedge clk) begin
        if (req_idle) begin
            resp_rdata_q <= '0;
            if (hit_gpio && !mem_we_i) begin
                resp_rdata_q <= {{(DATA_W-1){1'b0}}, gpio_rdata_i};
            end else if (hit_timer && !mem_we_i) begin
                resp_rdata_q <= {{(DATA_W-1){1'b0}}, timer_is_high_i};
            end
        end else if (state_q == st_sram_wait) begin
            resp_rdata_q <= req_we_q ? '0 : sram_rdata_i;
        end else if (state_q == st_flash_wait && flash_valid_i) begin
            resp_rdata_q <= flash_rdata_i;
        end
    end

    assign mem_rvalid_o = (state_q == st_respond) && !resp_err_q;
    assign mem_err_o    = (state_q == st_respond) && resp_err_q;
    assign mem_rdata_o  = (state_q == st_respond) ? resp_rdata_q : '0;

endmodule : mmu

//--- hdl/mmu_top.sv
`timescale 1ns/1ps

module mmu_top import mmu_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                mem_req_i,
    input  logic [31:0]         mem_addr_i,
    input  logic                mem_we_i,
    input  logic [DATA_W/8-1:0] mem_be_i,
    input  logic [DATA_W-1:0]   mem_wdata_i,
    output logic                mem_rvalid_o,
    output logic                mem_err_o,
    output logic [DATA_W-1:0]   mem_rdata_o,
    output logic                flash_cs_o,
    output logic                flash_sck_o,
    output logic                flash_mosi_o,
    input  logic                flash_miso_i,
    inout  wire  [GPIO_PINS-1:0] gpio_pins_io
);

    // Clock cycles per SCK half period
    localparam int unsigned FLASH_CLK_DIV = 2;

    logic                  sram_en;
    logic                  sram_we;
    logic [DATA_W/8-1:0]   sram_be;
    logic [SRAM_AW-1:0]    sram_addr;
    logic [DATA_W-1:0]     sram_wdata;
    logic [DATA_W-1:0]     sram_rdata;

    logic                  flash_start;
    logic [23:0]           flash_addr;
    logic                  flash_valid;
    logic [DATA_W-1:0]     flash_rdata;

    logic                  gpio_wr;
    logic                  gpio_rd;
    logic                  gpio_is_dir;
    logic [GPIO_IDX_W-1:0] gpio_index;
    logic                  gpio_wdata;
    logic                  gpio_rdata_bit;
    logic                  gpio_fault;

    logic                  timer_load;
    logic [DATA_W-1:0]     timer_value;
    logic                  timer_is_high;

    mmu mmu_i (
        .clk             (clk),
        .rst             (rst),
        .mem_req_i       (mem_req_i),
        .mem_addr_i      (mem_addr_i),
        .mem_we_i        (mem_we_i),
        .mem_be_i        (mem_be_i),
        .mem_wdata_i     (mem_wdata_i),
        .mem_rvalid_o    (mem_rvalid_o),
        .mem_err_o       (mem_err_o),
        .mem_rdata_o     (mem_rdata_o),
        .sram_en_o       (sram_en),
        .sram_we_o       (sram_we),
        .sram_be_o       (sram_be),
        .sram_addr_o     (sram_addr),
        .sram_wdata_o    (sram_wdata),
        .sram_rdata_i    (sram_rdata),
        .flash_start_o   (flash_start),
        .flash_addr_o    (flash_addr),
        .flash_valid_i   (flash_valid),
        .flash_rdata_i   (flash_rdata),
        .gpio_wr_o       (gpio_wr),
        .gpio_rd_o       (gpio_rd),
        .gpio_is_dir_o   (gpio_is_dir),
        .gpio_index_o    (gpio_index),
        .gpio_wdata_o    (gpio_wdata),
        .gpio_rdata_i    (gpio_rdata_bit),
        .gpio_fault_i    (gpio_fault),
        .timer_load_o    (timer_load),
        .timer_value_o   (timer_value),
        .timer_is_high_i (timer_is_high)
    );

    scratch_sram scratch_sram_i (
        .clk     (clk),
        .en_i    (sram_en),
        .we_i    (sram_we),
        .be_i    (sram_be),
        .addr_i  (sram_addr),
        .wdata_i (sram_wdata),
        .rdata_o (sram_rdata)
    );

    flash_reader #(
        .CLK_DIV (FLASH_CLK_DIV)
    ) flash_reader_i (
        .clk        (clk),
        .rst        (rst),
        .start_i    (flash_start),
        .addr_i     (flash_addr),
        .valid_o    (flash_valid),
        .rdata_o    (flash_rdata),
        .spi_cs_o   (flash_cs_o),
        .spi_sck_o  (flash_sck_o),
        .spi_mosi_o (flash_mosi_o),
        .spi_miso_i (flash_miso_i)
    );

    gpio_bank gpio_bank_i (
        .clk      (clk),
        .rst      (rst),
        .wr_i     (gpio_wr),
        .rd_i     (gpio_rd),
        .is_dir_i (gpio_is_dir),
        .index_i  (gpio_index),
        .wdata_i  (gpio_wdata),
        .rdata_o  (gpio_rdata_bit),
        .fault_o  (gpio_fault),
        .pins_io  (gpio_pins_io)
    );

    digital_timer digital_timer_i (
        .clk       (clk),
        .rst       (rst),
        .load_i    (timer_load),
        .value_i   (timer_value),
        .is_high_o (timer_is_high)
    );

endmodule : mmu_top

//--- tb/flash_model.sv
`timescale 1ns/1ps

module flash_model (
    input  logic cs_i,
    input  logic sck_i,
    input  logic mosi_i,
    output logic miso_o
);

    logic [31:0] cmd_q;
    logic [31:0] data_q;
    int          rx_cnt;

    initial begin
        cmd_q  = '0;
        data_q = '0;
        rx_cnt = 0;
        miso_o = 1'b0;
    end

    always @(negedge cs_i) begin
        rx_cnt = 0;
    end

    // Command and address bits are taken on rising SCK
    always @(posedge sck_i) begin
        if (!cs_i && rx_cnt < 32) begin
            cmd_q  = {cmd_q[30:0], mosi_i};
            rx_cnt = rx_cnt + 1;
        end
    end

    // Data changes on falling SCK, ahead of the master's rising-edge sample
    always @(negedge sck_i) begin
        if (!cs_i && rx_cnt == 32) begin
            if (cmd_q[31:24] == 8'h03) begin
                data_q = {8'h00, cmd_q[23:0]} ^ 32'h5A5A_0000;
            end else begin
                // Unknown opcode, bus stays high
                data_q = 32'hFFFF_FFFF;
            end
            miso_o = data_q[31];
            data_q = {data_q[30:0], 1'b0};
            rx_cnt = rx_cnt + 1;
        end else if (!cs_i && rx_cnt > 32) begin
            miso_o = data_q[31];
            data_q = {data_q[30:0], 1'b0};
        end
    end

endmodule : flash_model

//--- tb/mmu_asserts.sv
`timescale 1ns/1ps

module mmu_asserts import mmu_pkg::*; (
    input logic       clk,
    input logic       rst,
    input logic       rvalid_i,
    input logic       err_i,
    input logic       flash_start_i,
    input mmu_state_e state_i
);

    // A response is either good or an error
    resp_exclusive: assert property (@(posedge clk) disable iff (!rst)
        !(rvalid_i && err_i))
        else $error("mem_rvalid_o and mem_err_o high in the same cycle");

    resp_single_pulse: assert property (@(posedge clk) disable iff (!rst)
        (rvalid_i || err_i) |=> !(rvalid_i || err_i))
        else $error("response strobe held for more than one cycle");

    // A start leaves st_idle for the flash wait
    start_in_idle: assert property (@(posedge clk) disable iff (!rst)
        flash_start_i |-> (state_i == st_idle) ##1 (state_i == st_flash_wait))
        else $error("flash_start_o raised outside st_idle or without a flash wait");

    // First cycle out of reset
    quiet_after_reset: assert property (@(posedge clk)
        $rose(rst) |-> (!rvalid_i && !err_i))
        else $error("response strobe high right after reset");

endmodule : mmu_asserts

bind mmu mmu_asserts mmu_asserts_i (
    .clk           (clk),
    .rst           (rst),
    .rvalid_i      (mem_rvalid_o),
    .err_i         (mem_err_o),
    .flash_start_i (flash_start_o),
    .state_i       (state_q)
);

//--- tb/mmu_tb.sv
`timescale 1ns/1ps

module mmu_tb import mmu_pkg::*; ();

    localparam int unsigned CLK_PERIOD = 4;
    localparam int unsigned N_SRAM     = 16;
    localparam int unsigned N_FLASH    = 8;
    localparam int unsigned N_MIXED    = 80;
    // Worst flash read in clk cycles is 64 SCK periods of 4 clocks plus overhead
    localparam int unsigned FLASH_LAT  = 2 * 2 * 64 + 10;
    localparam int unsigned N_ACCESS   = 3 * N_SRAM + 2 * N_FLASH + 4 + 16 + 30 + 4 + N_MIXED;

    logic        clk;
    logic        rst;
    logic        mem_req;
    logic [31:0] mem_addr;
    logic        mem_we;
    logic [3:0]  mem_be;
    logic [31:0] mem_wdata;
    logic        mem_rvalid;
    logic        mem_err;
    logic [31:0] mem_rdata;
    logic        flash_cs;
    logic        flash_sck;
    logic        flash_mosi;
    logic        flash_miso;
    wire  [GPIO_PINS-1:0] gpio_pins;

    // Reference model state
    logic [31:0]          sram_shadow [1024];
    logic [31:0]          sram_addrs [N_SRAM];
    logic [31:0]          flash_addrs [N_FLASH];
    logic [GPIO_PINS-1:0] gpio_dir = '0;
    logic [GPIO_PINS-1:0] gpio_val = '0;
    logic [GPIO_PINS-1:0] pin_drive = '0;
    logic [31:0]          timer_value = '0;
    longint               timer_cycle = 0;
    longint               cycle_cnt = 0;

    logic [32:0] exp_q [$];
    logic [31:0] addr_q [$];

    int     check_cnt = 0;
    int     err_cnt = 0;
    int     test_checks = 0;
    int     test_errs = 0;
    integer seed = 32'h422c_2f0b;

    mmu_top mmu_top_i (
        .clk          (clk),
        .rst          (rst),
        .mem_req_i    (mem_req),
        .mem_addr_i   (mem_addr),
        .mem_we_i     (mem_we),
        .mem_be_i     (mem_be),
        .mem_wdata_i  (mem_wdata),
        .mem_rvalid_o (mem_rvalid),
        .mem_err_o    (mem_err),
        .mem_rdata_o  (mem_rdata),
        .flash_cs_o   (flash_cs),
        .flash_sck_o  (flash_sck),
        .flash_mosi_o (flash_mosi),
        .flash_miso_i (flash_miso),
        .gpio_pins_io (gpio_pins)
    );

    flash_model flash_model_i (
        .cs_i   (flash_cs),
        .sck_i  (flash_sck),
        .mosi_i (flash_mosi),
        .miso_o (flash_miso)
    );

    // Pins set as input are driven from here
    for (genvar i = 0; i < GPIO_PINS; i++) begin : g_pin_drv
        assign gpio_pins[i] = gpio_dir[i] ? pin_drive[i] : 1'bz;
    end

    initial begin
        clk = 1'b0;
    end

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // Expected {err, rdata} for one access from the address map rules
    function automatic logic [32:0] expect_response(input logic [31:0] addr, input logic we,
                                                    input longint req_cycle);
        int          idx;
        logic [23:0] off;
        if (addr >= FLASH_BASE) begin
            off = 24'(addr - FLASH_BASE);
            return we ? {1'b1, 32'h0} : {1'b0, {8'h00, off} ^ 32'h5A5A_0000};
        end
        if (addr >= SRAM_BASE && addr <= SRAM_LAST) begin
            return we ? 33'h0 : {1'b0, sram_shadow[(addr - SRAM_BASE) >> 2]};
        end
        if (addr >= GPIO_DIR_BASE && addr <= GPIO_DIR_LAST) begin
            idx = addr - GPIO_DIR_BASE;
            return we ? 33'h0 : {1'b0, 31'h0, gpio_dir[idx]};
        end
        if (addr >= GPIO_VAL_BASE && addr <= GPIO_VAL_LAST) begin
            idx = addr - GPIO_VAL_BASE;
            if (we) begin
                return gpio_dir[idx] ? {1'b1, 32'h0} : 33'h0;
            end
            return gpio_dir[idx] ? {1'b0, 31'h0, pin_drive[idx]} : {1'b1, 32'h0};
        end
        if (addr == TIMER_ADDR) begin
            // Count is loaded one cycle after the write request is seen
            if (we) begin
                return 33'h0;
            end
            return {1'b0, 31'h0, (req_cycle - timer_cycle) <= longint'(timer_value)};
        end
        return {1'b1, 32'h0};
    endfunction

    function automatic void update_model(input logic [31:0] addr, input logic we,
                                         input logic [3:0] be, input logic [31:0] wdata,
                                         input longint req_cycle);
        int idx;
        if (!we) begin
            return;
        end
        if (addr >= SRAM_BASE && addr <= SRAM_LAST) begin
            idx = (addr - SRAM_BASE) >> 2;
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    sram_shadow[idx][b*8 +: 8] = wdata[b*8 +: 8];
                end
            end
        end else if (addr >= GPIO_DIR_BASE && addr <= GPIO_DIR_LAST) begin
            gpio_dir[addr - GPIO_DIR_BASE] = wdata[0];
        end else if (addr >= GPIO_VAL_BASE && addr <= GPIO_VAL_LAST) begin
            idx = addr - GPIO_VAL_BASE;
            if (!gpio_dir[idx]) begin
                gpio_val[idx] = wdata[0];
            end
        end else if (addr == TIMER_ADDR) begin
            timer_value = wdata;
            timer_cycle = req_cycle;
        end
    endfunction

    function automatic logic [31:0] rand_reserved();
        if ($random(seed) & 1) begin
            return {$random(seed)} % 32'h101;
        end
        return 32'h116 + {$random(seed)} % (32'h1000 - 32'h116);
    endfunction

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // One request and a wait for its response pulse
    task automatic issue_access(input logic [31:0] addr, input logic we, input logic [3:0] be,
                                input logic [31:0] wdata);
        longint req_cycle;
        @(posedge clk);
        req_cycle = cycle_cnt;
        exp_q.push_back(expect_response(addr, we, req_cycle));
        addr_q.push_back(addr);
        update_model(addr, we, be, wdata, req_cycle);
        mem_req   <= 1'b1;
        mem_addr  <= addr;
        mem_we    <= we;
        mem_be    <= be;
        mem_wdata <= wdata;
        @(posedge clk);
        mem_req <= 1'b0;
        do begin
            @(posedge clk);
        end while (!(mem_rvalid || mem_err));
    endtask

    task automatic finish_test(input string name);
        @(negedge clk);
        $display("test %s done: %0d checks, %0d errors", name,
                 check_cnt - test_checks, err_cnt - test_errs);
        test_checks = check_cnt;
        test_errs   = err_cnt;
    endtask

    // Compare each response with the oldest expected one
    always @(posedge clk) begin : compare
        logic [32:0] exp;
        logic [31:0] addr;
        if (rst && (mem_rvalid || mem_err)) begin
            if (exp_q.size() == 0) begin
                err_cnt++;
                $display("Response at %0d ns arrived with no access pending", $time);
            end else begin
                exp  = exp_q.pop_front();
                addr = addr_q.pop_front();
                check($sformatf("err flag at %h", addr), {31'h0, mem_err}, {31'h0, exp[32]});
                if (!exp[32]) begin
                    check($sformatf("rdata at %h", addr), mem_rdata, exp[31:0]);
                end
            end
        end
    end

    initial begin : stimulus
        logic [31:0] addr;
        logic [31:0] data;
        logic        we;
        mem_req   <= 1'b0;
        mem_addr  <= '0;
        mem_we    <= 1'b0;
        mem_be    <= '0;
        mem_wdata <= '0;
        rst       <= 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b1;
        repeat (2) @(posedge clk);

        // Idle SPI bus and output pins driving 0
        check("flash_cs_o after reset", {31'h0, flash_cs}, 32'h1);
        check("flash_sck_o after reset", {31'h0, flash_sck}, 32'h0);
        check("gpio pins after reset", {22'h0, gpio_pins}, 32'h0);
        finish_test("reset");

        // SRAM full-word writes first so no byte stays unknown
        for (int i = 0; i < N_SRAM; i++) begin
            sram_addrs[i] = SRAM_BASE + (({$random(seed)} & 32'h3FF) << 2);
            issue_access(sram_addrs[i], 1'b1, 4'hF, $random(seed));
        end
        for (int i = 0; i < N_SRAM; i++) begin
            issue_access(sram_addrs[i], 1'b1, 4'($random(seed)), $random(seed));
        end
        for (int i = 0; i < N_SRAM; i++) begin
            issue_access(sram_addrs[i], 1'b0, 4'h0, 32'h0);
        end
        finish_test("sram");

        // Flash reads then failing writes then the same reads again
        for (int i = 0; i < N_FLASH; i++) begin
            flash_addrs[i] = FLASH_BASE + ({$random(seed)} & 32'h00FF_FFFC);
            issue_access(flash_addrs[i], 1'b0, 4'h0, 32'h0);
        end
        for (int i = 0; i < 4; i++) begin
            issue_access(flash_addrs[i], 1'b1, 4'hF, $random(seed));
        end
        for (int i = 0; i < N_FLASH; i++) begin
            issue_access(flash_addrs[i], 1'b0, 4'h0, 32'h0);
        end
        finish_test("flash");

        // Reserved holes at both edges and a few addresses inside
        for (int i = 0; i < 8; i++) begin
            case (i)
                0: addr = 32'h0000_0000;
                1: addr = 32'h0000_0100;
                2: addr = 32'h0000_0116;
                3: addr = 32'h0000_0FFF;
                default: addr = rand_reserved();
            endcase
            issue_access(addr, 1'b0, 4'h0, 32'h0);
            issue_access(addr, 1'b1, 4'hF, $random(seed));
        end
        finish_test("reserved");

        // GPIO pins 0 to 4 become inputs
        for (int i = 0; i < 5; i++) begin
            issue_access(GPIO_DIR_BASE + i, 1'b1, 4'hF, 32'h1);
        end
        for (int i = 0; i < GPIO_PINS; i++) begin
            issue_access(GPIO_DIR_BASE + i, 1'b0, 4'h0, 32'h0);
        end
        for (int i = 5; i < GPIO_PINS; i++) begin
            issue_access(GPIO_VAL_BASE + i, 1'b1, 4'hF, $random(seed));
        end
        for (int i = 5; i < GPIO_PINS; i++) begin
            check($sformatf("level of pin %0d", i), {31'h0, gpio_pins[i]}, {31'h0, gpio_val[i]});
        end
        pin_drive = 10'($random(seed));
        for (int i = 0; i < 5; i++) begin
            issue_access(GPIO_VAL_BASE + i, 1'b0, 4'h0, 32'h0);
        end
        issue_access(GPIO_VAL_BASE + 2, 1'b1, 4'hF, 32'h1);
        issue_access(GPIO_VAL_BASE + 7, 1'b0, 4'h0, 32'h0);
        finish_test("gpio");

        // Timer
        issue_access(TIMER_ADDR, 1'b1, 4'hF, 32'h0010_0000);
        issue_access(TIMER_ADDR, 1'b0, 4'h0, 32'h0);
        issue_access(TIMER_ADDR, 1'b1, 4'hF, 32'd3);
        repeat (20) @(posedge clk);
        issue_access(TIMER_ADDR, 1'b0, 4'h0, 32'h0);
        finish_test("timer");

        // Mixed stream over every region
        for (int n = 0; n < N_MIXED; n++) begin
            data = $random(seed);
            we   = $random(seed);
            case ({$random(seed)} % 6)
                0: issue_access(sram_addrs[{$random(seed)} % N_SRAM], we, 4'($random(seed)), data);
                1: issue_access(FLASH_BASE + ({$random(seed)} & 32'h00FF_FFFF), we, 4'hF, data);
                2: issue_access(rand_reserved(), we, 4'hF, data);
                3: issue_access(GPIO_DIR_BASE + {$random(seed)} % GPIO_PINS, we, 4'hF, data);
                4: begin
                    pin_drive = 10'($random(seed));
                    issue_access(GPIO_VAL_BASE + {$random(seed)} % GPIO_PINS, we, 4'hF, data);
                end
                default: issue_access(TIMER_ADDR, we, 4'hF, data & 32'h3F);
            endcase
        end
        finish_test("mixed");

        $display("all tests: %0d checks, %0d errors", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Every access as slow as a flash read plus margin for reset and timer waits
    initial begin : watchdog
        #(CLK_PERIOD * (N_ACCESS * FLASH_LAT + 1000));
        $display("Timeout: the DUT stopped answering before all tests ran");
        $display("Finished with errors");
        $finish;
    end

endmodule : mmu_tb

//--- sources.f
hdl/mmu_pkg.sv
hdl/scratch_sram.sv
hdl/flash_reader.sv
hdl/gpio_bank.sv
hdl/digital_timer.sv
hdl/mmu.sv
hdl/mmu_top.sv
tb/flash_model.sv
tb/mmu_asserts.sv
tb/mmu_tb.sv

//--- Bender.yml
package:
  name: mmu

sources:
  - hdl/mmu_pkg.sv
  - hdl/scratch_sram.sv
  - hdl/flash_reader.sv
  - hdl/gpio_bank.sv
  - hdl/digital_timer.sv
  - hdl/mmu.sv
  - hdl/mmu_top.sv
  - target: test
    files:
      - tb/flash_model.sv
      - tb/mmu_asserts.sv
      - tb/mmu_tb.sv
